/* design/stlb_pkg.sv */
`default_nettype none

package stlb_pkg;

  // ------------------------------
  // Geometry
  // ------------------------------
  localparam int unsigned N_ASSOC   = 4;
  localparam int unsigned WAY_BITS  = 2;
  localparam int unsigned TLB_ORDER = 10;
  localparam int unsigned TLB_SIZE  = 2 ** TLB_ORDER;

  // Address and id widths, 4 KiB pages only
  localparam int unsigned VADDR_BITS = 48;
  localparam int unsigned PG_BITS    = 12;
  localparam int unsigned VPN_BITS   = VADDR_BITS - PG_BITS;
  localparam int unsigned PPN_BITS   = 32;
  localparam int unsigned PID_BITS   = 6;

  // Replacement bookkeeping
  localparam int unsigned REF_BITS       = 8;
  localparam int unsigned REF_CLR_PERIOD = 65536;

  // ------------------------------
  // Field types
  // ------------------------------
  typedef logic [WAY_BITS-1:0]  way_t;
  typedef logic [VPN_BITS-1:0]  vpn_t;
  typedef logic [PPN_BITS-1:0]  ppn_t;
  typedef logic [PID_BITS-1:0]  pid_t;
  typedef logic [TLB_ORDER:0]   valid_sz_t;
  typedef logic [REF_BITS-1:0]  ref_cnt_t;

  // Update beat, valid=0 requests a delete
  typedef struct packed {
    logic valid;
    pid_t pid;
    vpn_t vpn;
    ppn_t ppn;
  } update_word_t;

endpackage

`default_nettype wire

/* design/stlb_paddr_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module stlb_paddr_ram (
  input  logic                           aclk,
  input  logic                           wr_en,
  input  logic [stlb_pkg::TLB_ORDER-1:0] wr_addr,
  input  stlb_pkg::ppn_t                 wr_data,
  input  logic [stlb_pkg::TLB_ORDER-1:0] rd_addr,
  output stlb_pkg::ppn_t                 rd_data
);

  // One physical page number per page of the way's range
  stlb_pkg::ppn_t mem [stlb_pkg::TLB_SIZE];

  // Write side, driven by the update controller
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Lookup side, one cycle of latency
  always_ff @(posedge aclk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* design/stlb_entry_table.sv */
`timescale 1ns/100ps
`default_nettype none

module stlb_entry_table (
  input  logic                                                aclk,
  input  logic                                                aresetn,
  input  logic                                                new_en,
  input  stlb_pkg::vpn_t                                      new_vpn,
  input  stlb_pkg::pid_t                                      new_pid,
  input  logic                                                append_en,
  input  stlb_pkg::way_t                                      append_way,
  input  logic                                                delete_en,
  input  stlb_pkg::way_t                                      delete_way,
  input  logic                                                ref_inc_en,
  input  stlb_pkg::way_t                                      ref_inc_way,
  output stlb_pkg::vpn_t      [stlb_pkg::N_ASSOC-1:0]         entry_vpn,
  output stlb_pkg::pid_t      [stlb_pkg::N_ASSOC-1:0]         entry_pid,
  output stlb_pkg::valid_sz_t [stlb_pkg::N_ASSOC-1:0]         entry_valid_sz,
  output stlb_pkg::way_t                                      victim_way
);

  stlb_pkg::ref_cnt_t [stlb_pkg::N_ASSOC-1:0] ref_cnt;

  // Aging timer, wraps after reaching the period
  logic [$clog2(stlb_pkg::REF_CLR_PERIOD+1)-1:0] age_tmr;
  logic age_tick;

  logic               found_empty;
  stlb_pkg::way_t     empty_way;
  stlb_pkg::way_t     lru_way;
  stlb_pkg::ref_cnt_t min_ref;

  assign age_tick = (age_tmr == stlb_pkg::REF_CLR_PERIOD);

  // ------------------------------
  // Entry records
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      age_tmr <= '0;
      for (int i = 0; i < stlb_pkg::N_ASSOC; i++) begin
        entry_vpn[i]      <= '0;
        entry_pid[i]      <= '0;
        entry_valid_sz[i] <= '0;
        ref_cnt[i]        <= '0;
      end
    end else begin
      if (age_tick) begin
        age_tmr <= '0;
        for (int i = 0; i < stlb_pkg::N_ASSOC; i++) begin
          ref_cnt[i] <= ref_cnt[i] >> 1;
        end
      end else begin
        age_tmr <= age_tmr + 1'b1;
      end

      // Lookup hit; on an aging tick the count is halved first
      if (ref_inc_en) begin
        if (age_tick) begin
          ref_cnt[ref_inc_way] <= (ref_cnt[ref_inc_way] >> 1) + 1'b1;
        end else begin
          ref_cnt[ref_inc_way] <= ref_cnt[ref_inc_way] + 1'b1;
        end
      end

      // New entries always land in the current victim
      if (new_en) begin
        entry_vpn[victim_way]      <= new_vpn;
        entry_pid[victim_way]      <= new_pid;
        entry_valid_sz[victim_way] <= stlb_pkg::valid_sz_t'(1);
        ref_cnt[victim_way]        <= stlb_pkg::ref_cnt_t'(1);
      end
      if (append_en) begin
        entry_valid_sz[append_way] <= entry_valid_sz[append_way] + 1'b1;
      end
      if (delete_en) begin
        entry_valid_sz[delete_way] <= '0;
      end
    end
  end

  // ------------------------------
  // Victim selection
  // ------------------------------
  always_comb begin
    found_empty = 1'b0;
    empty_way   = '0;
    lru_way     = '0;
    min_ref     = '1;
    // Scan downwards so the lowest empty way is kept
    for (int i = stlb_pkg::N_ASSOC - 1; i >= 0; i--) begin
      if (entry_valid_sz[i] == '0) begin
        found_empty = 1'b1;
        empty_way   = stlb_pkg::way_t'(i);
      end
    end
    // Ties go to the higher index
    for (int i = 0; i < stlb_pkg::N_ASSOC; i++) begin
      if (ref_cnt[i] <= min_ref) begin
        min_ref = ref_cnt[i];
        lru_way = stlb_pkg::way_t'(i);
      end
    end
  end

  assign victim_way = found_empty ? empty_way : lru_way;

endmodule

`default_nettype wire

/* design/stlb_update_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module stlb_update_ctrl (
  input  logic                                        aclk,
  input  logic                                        aresetn,
  input  logic                                        s_tvalid,
  input  stlb_pkg::update_word_t                      s_tdata,
  input  stlb_pkg::vpn_t      [stlb_pkg::N_ASSOC-1:0] entry_vpn,
  input  stlb_pkg::pid_t      [stlb_pkg::N_ASSOC-1:0] entry_pid,
  input  stlb_pkg::valid_sz_t [stlb_pkg::N_ASSOC-1:0] entry_valid_sz,
  input  stlb_pkg::way_t                              victim_way,
  output logic                                        s_tready,
  output logic                                        new_en,
  output stlb_pkg::vpn_t                              new_vpn,
  output stlb_pkg::pid_t                              new_pid,
  output logic                                        append_en,
  output stlb_pkg::way_t                              append_way,
  output logic                                        delete_en,
  output stlb_pkg::way_t                              delete_way,
  output logic [stlb_pkg::N_ASSOC-1:0]                pt_wr_en,
  output logic [stlb_pkg::TLB_ORDER-1:0]              pt_wr_addr,
  output stlb_pkg::ppn_t                              pt_wr_data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_MODIFY,
    ST_APPEND,
    ST_NEW,
    ST_DELETE
  } state_t;

  state_t state, state_nxt;

  stlb_pkg::update_word_t                    beat;
  stlb_pkg::vpn_t [stlb_pkg::N_ASSOC-1:0]    offset;
  logic                                      hit_modify, hit_append, hit_delete;
  stlb_pkg::way_t                            way_modify, way_append, way_delete;
  stlb_pkg::way_t                            sel_way;
  stlb_pkg::way_t                            act_way;
  logic [stlb_pkg::TLB_ORDER-1:0]            act_off;

  // ------------------------------
  // State and beat registers
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge aclk) begin
    if (state == ST_IDLE && s_tvalid) begin
      beat <= s_tdata;
    end
    // Way and page offset of the chosen action
    if (state == ST_CHECK) begin
      act_way <= sel_way;
      act_off <= offset[sel_way][stlb_pkg::TLB_ORDER-1:0];
    end
  end

  // ------------------------------
  // Hit detection, highest way wins
  // ------------------------------
  always_comb begin
    hit_modify = 1'b0;
    hit_append = 1'b0;
    hit_delete = 1'b0;
    way_modify = '0;
    way_append = '0;
    way_delete = '0;
    for (int i = 0; i < stlb_pkg::N_ASSOC; i++) begin
      offset[i] = beat.vpn - entry_vpn[i];
      if (beat.vpn >= entry_vpn[i]) begin
        if (offset[i] < entry_valid_sz[i]) begin
          // Delete ignores the pid
          hit_delete = 1'b1;
          way_delete = stlb_pkg::way_t'(i);
          if (beat.pid == entry_pid[i]) begin
            hit_modify = 1'b1;
            way_modify = stlb_pkg::way_t'(i);
          end
        end else if (offset[i] == entry_valid_sz[i] &&
                     entry_valid_sz[i] < stlb_pkg::TLB_SIZE &&
                     beat.pid == entry_pid[i]) begin
          hit_append = 1'b1;
          way_append = stlb_pkg::way_t'(i);
        end
      end
    end
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_nxt = state;
    sel_way   = way_delete;
    case (state)
      ST_IDLE: begin
        if (s_tvalid) begin
          state_nxt = ST_CHECK;
        end
      end
      ST_CHECK: begin
        if (beat.valid) begin
          if (hit_modify) begin
            state_nxt = ST_MODIFY;
            sel_way   = way_modify;
          end else if (hit_append) begin
            state_nxt = ST_APPEND;
            sel_way   = way_append;
          end else begin
            state_nxt = ST_NEW;
          end
        end else if (hit_delete) begin
          state_nxt = ST_DELETE;
        end else begin
          state_nxt = ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // ------------------------------
  // Action cycle outputs
  // ------------------------------
  assign s_tready   = (state == ST_IDLE);
  assign new_en     = (state == ST_NEW);
  assign append_en  = (state == ST_APPEND);
  assign delete_en  = (state == ST_DELETE);
  assign new_vpn    = beat.vpn;
  assign new_pid    = beat.pid;
  assign append_way = act_way;
  assign delete_way = act_way;
  assign pt_wr_data = beat.ppn;

  always_comb begin
    pt_wr_en   = '0;
    pt_wr_addr = act_off;
    case (state)
      ST_MODIFY, ST_APPEND: begin
        pt_wr_en[act_way] = 1'b1;
      end
      ST_NEW: begin
        // First page of a fresh range
        pt_wr_en[victim_way] = 1'b1;
        pt_wr_addr           = '0;
      end
      default: begin
        pt_wr_en = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/stlb_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module stlb_lookup (
  input  logic                                                 aclk,
  input  logic                                                 aresetn,
  input  logic                                                 tlb_valid,
  input  logic [stlb_pkg::VADDR_BITS-1:0]                      tlb_vaddr,
  input  stlb_pkg::pid_t                                       tlb_pid,
  input  stlb_pkg::vpn_t      [stlb_pkg::N_ASSOC-1:0]          entry_vpn,
  input  stlb_pkg::pid_t      [stlb_pkg::N_ASSOC-1:0]          entry_pid,
  input  stlb_pkg::valid_sz_t [stlb_pkg::N_ASSOC-1:0]          entry_valid_sz,
  input  stlb_pkg::ppn_t      [stlb_pkg::N_ASSOC-1:0]          pt_rd_data,
  output logic [stlb_pkg::N_ASSOC-1:0][stlb_pkg::TLB_ORDER-1:0] pt_rd_addr,
  output logic                                                 tlb_hit,
  output stlb_pkg::ppn_t                                       tlb_ppn,
  output logic                                                 ref_inc_en,
  output stlb_pkg::way_t                                       ref_inc_way
);

  // Stage 1, the sampled request
  logic           req_valid;
  stlb_pkg::vpn_t req_vpn;
  stlb_pkg::pid_t req_pid;

  stlb_pkg::vpn_t [stlb_pkg::N_ASSOC-1:0] offset;
  logic           hit;
  stlb_pkg::way_t hit_way;

  // Stages 2 and 3
  logic           valid_s2, hit_s2, hit_s3;
  stlb_pkg::way_t way_s2, way_s3;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      req_valid <= 1'b0;
      req_vpn   <= '0;
      req_pid   <= '0;
    end else begin
      req_valid <= tlb_valid;
      req_vpn   <= tlb_vaddr[stlb_pkg::VADDR_BITS-1:stlb_pkg::PG_BITS];
      req_pid   <= tlb_pid;
    end
  end

  // ------------------------------
  // Range match per way
  // ------------------------------
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int i = 0; i < stlb_pkg::N_ASSOC; i++) begin
      offset[i] = req_vpn - entry_vpn[i];
      if (req_vpn >= entry_vpn[i] && offset[i] < entry_valid_sz[i] &&
          req_pid == entry_pid[i]) begin
        hit     = 1'b1;
        hit_way = stlb_pkg::way_t'(i);
      end
    end
  end

  // ------------------------------
  // Pipeline
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      valid_s2 <= 1'b0;
      hit_s2   <= 1'b0;
      hit_s3   <= 1'b0;
      tlb_hit  <= 1'b0;
      tlb_ppn  <= '0;
    end else begin
      valid_s2 <= req_valid;
      hit_s2   <= hit;
      hit_s3   <= hit_s2;
      tlb_hit  <= hit_s3;
      // Memory data of the stage 3 request is on the read port now
      tlb_ppn  <= pt_rd_data[way_s3];
    end
  end

  always_ff @(posedge aclk) begin
    way_s2 <= hit_way;
    way_s3 <= way_s2;
    for (int i = 0; i < stlb_pkg::N_ASSOC; i++) begin
      pt_rd_addr[i] <= offset[i][stlb_pkg::TLB_ORDER-1:0];
    end
  end

  // Only real requests count as references
  assign ref_inc_en  = valid_s2 && hit_s2;
  assign ref_inc_way = way_s2;

endmodule

`default_nettype wire

/* design/stlb_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module stlb_controller (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            s_tvalid,
  output logic                            s_tready,
  input  stlb_pkg::update_word_t          s_tdata,
  input  logic                            tlb_valid,
  input  logic [stlb_pkg::VADDR_BITS-1:0] tlb_vaddr,
  input  stlb_pkg::pid_t                  tlb_pid,
  output logic                            tlb_hit,
  output stlb_pkg::ppn_t                  tlb_ppn
);

  // Entry state
  stlb_pkg::vpn_t      [stlb_pkg::N_ASSOC-1:0] entry_vpn;
  stlb_pkg::pid_t      [stlb_pkg::N_ASSOC-1:0] entry_pid;
  stlb_pkg::valid_sz_t [stlb_pkg::N_ASSOC-1:0] entry_valid_sz;
  stlb_pkg::way_t                              victim_way;

  // Table commands
  logic           new_en, append_en, delete_en, ref_inc_en;
  stlb_pkg::vpn_t new_vpn;
  stlb_pkg::pid_t new_pid;
  stlb_pkg::way_t append_way, delete_way, ref_inc_way;

  // Memory ports
  logic [stlb_pkg::N_ASSOC-1:0]                      pt_wr_en;
  logic [stlb_pkg::TLB_ORDER-1:0]                    pt_wr_addr;
  stlb_pkg::ppn_t                                    pt_wr_data;
  logic [stlb_pkg::N_ASSOC-1:0][stlb_pkg::TLB_ORDER-1:0] pt_rd_addr;
  stlb_pkg::ppn_t [stlb_pkg::N_ASSOC-1:0]            pt_rd_data;

  stlb_entry_table i_table (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .new_en         (new_en),
    .new_vpn        (new_vpn),
    .new_pid        (new_pid),
    .append_en      (append_en),
    .append_way     (append_way),
    .delete_en      (delete_en),
    .delete_way     (delete_way),
    .ref_inc_en     (ref_inc_en),
    .ref_inc_way    (ref_inc_way),
    .entry_vpn      (entry_vpn),
    .entry_pid      (entry_pid),
    .entry_valid_sz (entry_valid_sz),
    .victim_way     (victim_way)
  );

  stlb_update_ctrl i_update (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_tvalid       (s_tvalid),
    .s_tdata        (s_tdata),
    .entry_vpn      (entry_vpn),
    .entry_pid      (entry_pid),
    .entry_valid_sz (entry_valid_sz),
    .victim_way     (victim_way),
    .s_tready       (s_tready),
    .new_en         (new_en),
    .new_vpn        (new_vpn),
    .new_pid        (new_pid),
    .append_en      (append_en),
    .append_way     (append_way),
    .delete_en      (delete_en),
    .delete_way     (delete_way),
    .pt_wr_en       (pt_wr_en),
    .pt_wr_addr     (pt_wr_addr),
    .pt_wr_data     (pt_wr_data)
  );

  stlb_lookup i_lookup (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .tlb_valid      (tlb_valid),
    .tlb_vaddr      (tlb_vaddr),
    .tlb_pid        (tlb_pid),
    .entry_vpn      (entry_vpn),
    .entry_pid      (entry_pid),
    .entry_valid_sz (entry_valid_sz),
    .pt_rd_data     (pt_rd_data),
    .pt_rd_addr     (pt_rd_addr),
    .tlb_hit        (tlb_hit),
    .tlb_ppn        (tlb_ppn),
    .ref_inc_en     (ref_inc_en),
    .ref_inc_way    (ref_inc_way)
  );

  // One page memory per way, shared write address and data
  for (genvar i = 0; i < stlb_pkg::N_ASSOC; i++) begin : g_way
    stlb_paddr_ram i_ram (
      .aclk    (aclk),
      .wr_en   (pt_wr_en[i]),
      .wr_addr (pt_wr_addr),
      .wr_data (pt_wr_data),
      .rd_addr (pt_rd_addr[i]),
      .rd_data (pt_rd_data[i])
    );
  end

endmodule

`default_nettype wire

/* verification/stlb_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module stlb_clkgen (
  output logic aclk,
  output logic aresetn
);

  // 4 ns period
  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // Reset held over three rising edges
  initial begin
    aresetn = 1'b0;
    repeat (3) @(posedge aclk);
    #1 aresetn = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/stlb_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module stlb_asserts (
  input logic                   aclk,
  input logic                   aresetn,
  input logic                   s_tvalid,
  input logic                   s_tready,
  input stlb_pkg::update_word_t s_tdata,
  input logic                   tlb_hit
);

  int unsigned err_cnt = 0;

  // Check cycle follows every accepted beat
  ready_drops: assert property (@(posedge aclk) disable iff (!aresetn)
    s_tvalid && s_tready |=> !s_tready)
    else begin
      $error("s_tready stayed high in the cycle after a transfer");
      err_cnt++;
    end

  // Lookup pipeline is empty when reset ends
  hit_quiet: assert property (@(posedge aclk) $rose(aresetn) |-> !tlb_hit [*3])
    else begin
      $error("tlb_hit went high within three cycles of reset release");
      err_cnt++;
    end

  // Stalled beat held by the source
  data_held: assert property (@(posedge aclk) disable iff (!aresetn)
    s_tvalid && !s_tready |=> $stable(s_tdata))
    else begin
      $error("s_tdata changed while the beat was stalled");
      err_cnt++;
    end

endmodule

bind stlb_controller stlb_asserts i_asserts (
  .aclk     (aclk),
  .aresetn  (aresetn),
  .s_tvalid (s_tvalid),
  .s_tready (s_tready),
  .s_tdata  (s_tdata),
  .tlb_hit  (tlb_hit)
);

`default_nettype wire

/* verification/stlb_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module stlb_tb;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int NW = stlb_pkg::N_ASSOC;

  logic                            aclk;
  logic                            aresetn;
  logic                            s_tvalid;
  logic                            s_tready;
  stlb_pkg::update_word_t          s_tdata;
  logic                            tlb_valid;
  logic [stlb_pkg::VADDR_BITS-1:0] tlb_vaddr;
  stlb_pkg::pid_t                  tlb_pid;
  logic                            tlb_hit;
  stlb_pkg::ppn_t                  tlb_ppn;

  // Reference model of four entries and a sparse page store keyed by way and offset
  stlb_pkg::vpn_t      m_base [NW];
  stlb_pkg::pid_t      m_pid  [NW];
  stlb_pkg::valid_sz_t m_len  [NW];
  stlb_pkg::ref_cnt_t  m_ref  [NW];
  stlb_pkg::ppn_t      m_ppn  [int];

  // Request on the lookup inputs and the three requests in flight
  logic           req_chk, req_hit;
  stlb_pkg::ppn_t req_ppn;
  stlb_pkg::vpn_t req_vpn;
  logic           pipe_chk [4];
  logic           pipe_hit [4];
  stlb_pkg::ppn_t pipe_ppn [4];
  stlb_pkg::vpn_t pipe_vpn [4];

  int     pending;
  int     cycle_cnt;
  integer seed;

  stlb_clkgen i_clkgen (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  stlb_controller i_dut (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .s_tdata   (s_tdata),
    .tlb_valid (tlb_valid),
    .tlb_vaddr (tlb_vaddr),
    .tlb_pid   (tlb_pid),
    .tlb_hit   (tlb_hit),
    .tlb_ppn   (tlb_ppn)
  );

  task automatic end_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic bit covers(int w, stlb_pkg::vpn_t vpn);
    return vpn >= m_base[w] && (vpn - m_base[w]) < m_len[w];
  endfunction

  function automatic int page_key(int w, stlb_pkg::vpn_t vpn);
    return w * stlb_pkg::TLB_SIZE + int'(vpn - m_base[w]);
  endfunction

  // Highest matching way or -1 on a miss
  function automatic int lookup_way(stlb_pkg::vpn_t vpn, stlb_pkg::pid_t pid);
    int w;
    w = -1;
    for (int i = 0; i < NW; i++) begin
      if (covers(i, vpn) && m_pid[i] == pid) w = i;
    end
    return w;
  endfunction

  // Expected {hit, ppn} of a lookup
  function automatic logic [stlb_pkg::PPN_BITS:0] ref_translate(stlb_pkg::vpn_t vpn,
                                                                stlb_pkg::pid_t pid);
    int w;
    w = lookup_way(vpn, pid);
    if (w < 0) return '0;
    return {1'b1, m_ppn[page_key(w, vpn)]};
  endfunction

  // First empty way or else the fewest references with ties to the higher way
  function automatic int ref_victim();
    int v;
    v = -1;
    for (int i = NW - 1; i >= 0; i--) begin
      if (m_len[i] == 0) v = i;
    end
    if (v >= 0) return v;
    v = 0;
    for (int i = 1; i < NW; i++) begin
      if (m_ref[i] <= m_ref[v]) v = i;
    end
    return v;
  endfunction

  function automatic void model_update(stlb_pkg::update_word_t w);
    int mod_w, app_w, del_w, v;
    mod_w = -1;
    app_w = -1;
    del_w = -1;
    for (int i = 0; i < NW; i++) begin
      if (covers(i, w.vpn)) begin
        del_w = i;
        if (w.pid == m_pid[i]) mod_w = i;
      end else if (w.vpn >= m_base[i] && w.vpn - m_base[i] == m_len[i] &&
                   m_len[i] < stlb_pkg::TLB_SIZE && w.pid == m_pid[i]) begin
        app_w = i;
      end
    end
    if (!w.valid) begin
      if (del_w >= 0) m_len[del_w] = '0;
    end else if (mod_w >= 0) begin
      m_ppn[page_key(mod_w, w.vpn)] = w.ppn;
    end else if (app_w >= 0) begin
      m_ppn[page_key(app_w, w.vpn)] = w.ppn;
      m_len[app_w] = m_len[app_w] + 1'b1;
    end else begin
      v = ref_victim();
      m_base[v] = w.vpn;
      m_pid[v]  = w.pid;
      m_len[v]  = 1;
      m_ref[v]  = 1;
      m_ppn[v * stlb_pkg::TLB_SIZE] = w.ppn;
    end
  endfunction

  // ------------------------------
  // Drivers entered and left 1 ns after a rising edge
  // ------------------------------
  // The beat may be presented while the DUT is still busy with the previous one
  task automatic send_update(logic valid, stlb_pkg::pid_t pid, stlb_pkg::vpn_t vpn,
                             stlb_pkg::ppn_t ppn);
    stlb_pkg::update_word_t w;
    w.valid  = valid;
    w.pid    = pid;
    w.vpn    = vpn;
    w.ppn    = ppn;
    s_tdata  = w;
    s_tvalid = 1'b1;
    @(negedge aclk);
    while (!s_tready) @(negedge aclk);
    @(posedge aclk);
    #1;
    s_tvalid = 1'b0;
    model_update(w);
  endtask

  task automatic issue_lookup(stlb_pkg::vpn_t vpn, stlb_pkg::pid_t pid);
    logic [stlb_pkg::PPN_BITS:0]   exp;
    logic [stlb_pkg::PG_BITS-1:0]  pg_off;
    int                            w;
    // Back to idle means the table has taken the last beat
    while (!s_tready) begin
      @(posedge aclk);
      #1;
    end
    exp    = ref_translate(vpn, pid);
    w      = lookup_way(vpn, pid);
    pg_off = $random(seed);
    if (w >= 0) m_ref[w] = m_ref[w] + 1'b1;
    tlb_valid = 1'b1;
    tlb_vaddr = {vpn, pg_off};
    tlb_pid   = pid;
    req_chk   = 1'b1;
    req_hit   = exp[stlb_pkg::PPN_BITS];
    req_ppn   = exp[stlb_pkg::PPN_BITS-1:0];
    req_vpn   = vpn;
    pending++;
    @(posedge aclk);
    #1;
    tlb_valid = 1'b0;
    req_chk   = 1'b0;
  endtask

  task automatic drain();
    while (pending != 0) begin
      @(posedge aclk);
      #1;
    end
  endtask

  // ------------------------------
  // Compare three edges after sampling
  // ------------------------------
  always begin
    @(posedge aclk);
    for (int i = 3; i > 0; i--) begin
      pipe_chk[i] = pipe_chk[i-1];
      pipe_hit[i] = pipe_hit[i-1];
      pipe_ppn[i] = pipe_ppn[i-1];
      pipe_vpn[i] = pipe_vpn[i-1];
    end
    pipe_chk[0] = req_chk;
    pipe_hit[0] = req_hit;
    pipe_ppn[0] = req_ppn;
    pipe_vpn[0] = req_vpn;
    @(negedge aclk);
    if (pipe_chk[3]) begin
      assert (tlb_hit === pipe_hit[3]) else begin
        $display("FAILED at %0t: vpn %h expected hit %0b, got %b", $time, pipe_vpn[3],
                 pipe_hit[3], tlb_hit);
        end_with_failure();
      end
      if (pipe_hit[3]) begin
        assert (tlb_ppn === pipe_ppn[3]) else begin
          $display("FAILED at %0t: vpn %h expected ppn %h, got %h", $time, pipe_vpn[3],
                   pipe_ppn[3], tlb_ppn);
          end_with_failure();
        end
      end
      pending--;
    end
  end

  // Run limit and protocol monitor
  always @(posedge aclk) begin
    cycle_cnt++;
    if (i_dut.i_asserts.err_cnt != 0) begin
      $display("A protocol assertion on the DUT failed");
      end_with_failure();
    end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      end_with_failure();
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    stlb_pkg::vpn_t base_of [NW];
    stlb_pkg::pid_t pid_of  [NW];
    int             hits    [NW];
    logic [31:0]    r;
    seed      = 32'h112a;
    cycle_cnt = 0;
    pending   = 0;
    s_tvalid  = 1'b0;
    s_tdata   = '0;
    tlb_valid = 1'b0;
    tlb_vaddr = '0;
    tlb_pid   = '0;
    req_chk   = 1'b0;
    req_hit   = 1'b0;
    req_ppn   = '0;
    req_vpn   = '0;
    for (int i = 0; i < 4; i++) begin
      pipe_chk[i] = 1'b0;
    end
    for (int i = 0; i < NW; i++) begin
      m_base[i] = '0;
      m_pid[i]  = '0;
      m_len[i]  = '0;
      m_ref[i]  = '0;
    end
    base_of = '{36'h100, 36'h2000, 36'h3_0000, 36'h40_0000};
    pid_of  = '{6'd1, 6'd2, 6'd3, 6'd4};
    wait (aresetn === 1'b1);
    @(posedge aclk);
    #1;

    // Empty table
    repeat (16) issue_lookup(stlb_pkg::vpn_t'({$random(seed), $random(seed)}),
                             stlb_pkg::pid_t'($random(seed)));
    drain();

    // Fill ways 0 to 3
    for (int i = 0; i < NW; i++) begin
      send_update(1'b1, pid_of[i], base_of[i], stlb_pkg::ppn_t'($random(seed)));
    end
    for (int i = 0; i < NW; i++) issue_lookup(base_of[i], pid_of[i]);
    drain();

    // Grow the first range to 16 pages and miss one past the end
    for (int p = 1; p < 16; p++) begin
      send_update(1'b1, pid_of[0], base_of[0] + p, stlb_pkg::ppn_t'($random(seed)));
    end
    for (int p = 0; p <= 16; p++) issue_lookup(base_of[0] + p, pid_of[0]);
    drain();
    send_update(1'b1, pid_of[0], base_of[0] + 5, stlb_pkg::ppn_t'($random(seed)));
    issue_lookup(base_of[0] + 5, pid_of[0]);
    drain();

    // Wrong pid and then a delete with an unrelated pid
    issue_lookup(base_of[0], pid_of[1]);
    issue_lookup(base_of[1], pid_of[0]);
    drain();
    send_update(1'b0, 6'h3f, base_of[0] + 8, '0);
    send_update(1'b0, 6'h00, 36'hfff_ffff, '0);
    for (int p = 0; p < 16; p++) issue_lookup(base_of[0] + p, pid_of[0]);
    drain();
    base_of[0] = 36'h5000;
    pid_of[0]  = 6'd5;
    send_update(1'b1, pid_of[0], base_of[0], stlb_pkg::ppn_t'($random(seed)));
    issue_lookup(base_of[0], pid_of[0]);
    drain();

    // Uneven use with ways 1 and 2 tied at the minimum
    hits = '{5, 2, 2, 7};
    for (int i = 0; i < NW; i++) begin
      repeat (hits[i]) issue_lookup(base_of[i], pid_of[i]);
    end
    drain();
    send_update(1'b1, 6'd7, 36'h7_0000, stlb_pkg::ppn_t'($random(seed)));
    for (int i = 0; i < NW; i++) issue_lookup(base_of[i], pid_of[i]);
    issue_lookup(36'h7_0000, 6'd7);
    drain();
    base_of[2] = 36'h7_0000;
    pid_of[2]  = 6'd7;

    // Back-to-back mix of hits and misses
    repeat (200) begin
      r = $random(seed);
      if (r[2:0] < 3'd4) begin
        issue_lookup(base_of[r[1:0]], pid_of[r[1:0]]);
      end else if (r[2:0] < 3'd6) begin
        issue_lookup(36'h100 + r[7:4], 6'd1);
      end else if (r[2:0] == 3'd6) begin
        issue_lookup(base_of[r[4:3]], pid_of[r[4:3]] + 6'd8);
      end else begin
        issue_lookup(stlb_pkg::vpn_t'({r, r[15:0]}), stlb_pkg::pid_t'(r[13:8]));
      end
    end
    drain();

    if (i_dut.i_asserts.err_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("A protocol assertion on the DUT failed");
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
design/stlb_pkg.sv
design/stlb_paddr_ram.sv
design/stlb_entry_table.sv
design/stlb_update_ctrl.sv
design/stlb_lookup.sv
design/stlb_controller.sv
verification/stlb_clkgen.sv
verification/stlb_asserts.sv
verification/stlb_tb.sv

/* Bender.yml */
package:
  name: stlb

sources:
  - files:
      - design/stlb_pkg.sv
      - design/stlb_paddr_ram.sv
      - design/stlb_entry_table.sv
      - design/stlb_update_ctrl.sv
      - design/stlb_lookup.sv
      - design/stlb_controller.sv
  - target: simulation
    files:
      - verification/stlb_clkgen.sv
      - verification/stlb_asserts.sv
      - verification/stlb_tb.sv
